//--- verilog/lsu_pkg.sv
package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data and address width of the core
  localparam int unsigned XLEN   = 32;
  // byte lanes on the data bus
  localparam int unsigned NBYTES = XLEN / 8;
  // register file address width
  localparam int unsigned RALEN  = 5;

  ////////////////////
  // data ram
  ////////////////////

  // depth in words, any word address at or above this answers with an error
  localparam int unsigned RAM_WORDS = 256;
  // word index width
  localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

  // galois lfsr driving the ram request stalls
  localparam int unsigned LFSR_WIDTH = 16;
  localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 16'hace1;
  // x^16 + x^14 + x^13 + x^11, maximal length
  localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hb400;

  typedef logic [XLEN-1:0] xlen_t;

  // command encoding
  // bit 3 marks a write, bit 2 an unsigned load, bits 1:0 the access size
  // (00 byte, 01 half, 10 word)
  typedef enum logic [3:0] {
    LSU_LOAD_BYTE    = 4'b0000,
    LSU_LOAD_HALF    = 4'b0001,
    LSU_LOAD_WORD    = 4'b0010,
    LSU_LOAD_BYTE_U  = 4'b0100,
    LSU_LOAD_HALF_U  = 4'b0101,
    LSU_STORE_BYTE   = 4'b1000,
    LSU_STORE_HALF   = 4'b1001,
    LSU_STORE_WORD   = 4'b1010
  } lsu_cmd_e;

  // accepted core request, waiting for the bus
  typedef struct packed {
    lsu_cmd_e         cmd;
    xlen_t            addr;
    xlen_t            data;
    logic [RALEN-1:0] regdest;
  } lsu_req_t;

  // access in flight on the bus
  // full address kept so a bus error can report it
  typedef struct packed {
    lsu_cmd_e         cmd;
    xlen_t            addr;
    logic [RALEN-1:0] regdest;
  } lsu_act_t;

  // bus response as returned by the ram
  typedef struct packed {
    xlen_t data;
    logic  error;
  } lsu_rsp_t;

endpackage

//--- verilog/data_bus_if.sv
`timescale 1ns/1ps

interface data_bus_if import lsu_pkg::*; ();

  // request channel, master to slave except req_ready
  xlen_t             req_addr;
  xlen_t             req_data;
  logic [NBYTES-1:0] req_strobe;
  logic              req_write;
  logic              req_valid;
  logic              req_ready;

  // response channel, returns in request order
  xlen_t rsp_data;
  logic  rsp_error;
  logic  rsp_valid;
  logic  rsp_ready;

  // lsu side
  modport master (
    output req_addr, req_data, req_strobe, req_write, req_valid, rsp_ready,
    input  req_ready, rsp_data, rsp_error, rsp_valid
  );

  // memory side
  modport slave (
    input  req_addr, req_data, req_strobe, req_write, req_valid, rsp_ready,
    output req_ready, rsp_data, rsp_error, rsp_valid
  );

endinterface

//--- verilog/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rstn_i,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;

  logic in_fire;
  logic main_load;

  // ready only depends on the skid slot, so it comes straight from a flop
  assign in_ready_o  = ~skid_valid;
  assign out_valid_o = main_valid;
  assign out_data_o  = main_data;

  assign in_fire   = in_valid_i & in_ready_o;
  // main slot is free or being drained this cycle
  assign main_load = ~main_valid | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (~rstn_i) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      // skid entry is older, it moves up first
      main_valid <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      // main stuck, park the new entry
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : in_data_i;
    end
    if (in_ready_o) begin
      skid_data <= in_data_i;
    end
  end

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import lsu_pkg::*; (
  input  logic             clk_i,
  input  logic             rstn_i,

  // core side
  input  logic             lsu_valid_i,
  output logic             lsu_ready_o,
  input  lsu_cmd_e         lsu_cmd_i,
  input  xlen_t            lsu_addr_i,
  input  xlen_t            lsu_data_i,
  input  logic [RALEN-1:0] lsu_regdest_i,

  // register file write-back
  output xlen_t            rf_data_o,
  output logic             rf_wb_o,
  output logic [RALEN-1:0] rf_dest_o,

  // controller
  output logic             ctrl_misaligned_load_o,
  output logic             ctrl_misaligned_store_o,
  output logic             ctrl_bus_error_o,
  output xlen_t            ctrl_exception_addr_o,

  data_bus_if.master       bus
);

  typedef enum logic [1:0] {
    ST_RUN,   // taking commands
    ST_READ,  // load outstanding, wait for its write-back
    ST_FULL   // request buffer full
  } lsu_state_e;

  lsu_state_e state, state_next;

  function automatic logic is_write(input lsu_cmd_e cmd);
    return cmd[3];
  endfunction

  // half needs an even address, word a multiple of 4
  function automatic logic is_misaligned(input lsu_cmd_e cmd, input logic [1:0] off);
    logic bad;
    case (cmd[1:0])
      2'b01:   bad = off[0];
      2'b10:   bad = |off;
      default: bad = 1'b0;
    endcase
    return bad;
  endfunction

  function automatic logic [NBYTES-1:0] cmd_to_strobe(input lsu_cmd_e cmd,
                                                      input logic [1:0] off);
    logic [NBYTES-1:0] base;
    case (cmd[1:0])
      2'b00:   base = 4'b0001;
      2'b01:   base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << off;
  endfunction

  // pick the addressed lane and extend it to a full register
  function automatic xlen_t load_extract(input xlen_t word, input lsu_cmd_e cmd,
                                         input logic [1:0] off);
    xlen_t lane;
    xlen_t ret;
    lane = word >> {off, 3'b000};
    case (cmd)
      LSU_LOAD_BYTE:   ret = {{(XLEN-8){lane[7]}}, lane[7:0]};
      LSU_LOAD_HALF:   ret = {{(XLEN-16){lane[15]}}, lane[15:0]};
      LSU_LOAD_BYTE_U: ret = {{(XLEN-8){1'b0}}, lane[7:0]};
      LSU_LOAD_HALF_U: ret = {{(XLEN-16){1'b0}}, lane[15:0]};
      default:         ret = lane;
    endcase
    return ret;
  endfunction

  logic     lsu_fire;
  logic     misaligned;
  logic     load_accept;
  logic     load_done_q;

  logic     req_in_valid;
  logic     req_in_ready;
  lsu_req_t req_in;
  logic     req_out_valid;
  lsu_req_t req_out;

  logic     act_in_ready;
  lsu_act_t act_in;
  logic     act_out_valid;
  lsu_act_t act_out;

  logic     rsp_out_valid;
  lsu_rsp_t rsp_in;
  lsu_rsp_t rsp_out;

  logic     retire;

  ////////////////////
  // core side
  ////////////////////

  assign lsu_fire    = lsu_valid_i & lsu_ready_o;
  assign misaligned  = is_misaligned(lsu_cmd_i, lsu_addr_i[1:0]);
  // misaligned commands are consumed here and never reach the buffer
  assign req_in_valid = lsu_fire & ~misaligned;
  assign load_accept  = req_in_valid & ~is_write(lsu_cmd_i);

  always_comb begin
    req_in.cmd     = lsu_cmd_i;
    req_in.addr    = lsu_addr_i;
    req_in.data    = lsu_data_i;
    req_in.regdest = lsu_regdest_i;
  end

  skid_buffer #(
    .payload_t (lsu_req_t)
  ) request_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (req_in_valid),
    .in_ready_o  (req_in_ready),
    .in_data_i   (req_in),
    .out_valid_o (req_out_valid),
    .out_ready_i (bus.req_ready & act_in_ready),
    .out_data_o  (req_out)
  );

  ////////////////////
  // bus side
  ////////////////////

  // no issue while the active buffer has no room for the record
  assign bus.req_valid  = req_out_valid & act_in_ready;
  assign bus.req_addr   = {req_out.addr[XLEN-1:2], 2'b00};
  assign bus.req_data   = req_out.data << {req_out.addr[1:0], 3'b000};
  assign bus.req_strobe = cmd_to_strobe(req_out.cmd, req_out.addr[1:0]);
  assign bus.req_write  = is_write(req_out.cmd);
  assign bus.rsp_ready  = 1'b1;

  always_comb begin
    act_in.cmd     = req_out.cmd;
    act_in.addr    = req_out.addr;
    act_in.regdest = req_out.regdest;
    rsp_in.data    = bus.rsp_data;
    rsp_in.error   = bus.rsp_error;
  end

  skid_buffer #(
    .payload_t (lsu_act_t)
  ) active_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (bus.req_valid & bus.req_ready),
    .in_ready_o  (act_in_ready),
    .in_data_i   (act_in),
    .out_valid_o (act_out_valid),
    .out_ready_i (retire),
    .out_data_o  (act_out)
  );

  // never holds more entries than the active buffer, so it always has room
  skid_buffer #(
    .payload_t (lsu_rsp_t)
  ) response_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (bus.rsp_valid),
    .in_ready_o  (),
    .in_data_i   (rsp_in),
    .out_valid_o (rsp_out_valid),
    .out_ready_i (retire),
    .out_data_o  (rsp_out)
  );

  ////////////////////
  // retirement
  ////////////////////

  // oldest access and its response meet here
  assign retire = act_out_valid & rsp_out_valid;

  always_ff @(posedge clk_i) begin
    if (~rstn_i) begin
      rf_wb_o                 <= 1'b0;
      ctrl_bus_error_o        <= 1'b0;
      ctrl_misaligned_load_o  <= 1'b0;
      ctrl_misaligned_store_o <= 1'b0;
      load_done_q             <= 1'b0;
    end else begin
      rf_wb_o                 <= retire & ~is_write(act_out.cmd) & ~rsp_out.error;
      ctrl_bus_error_o        <= retire & rsp_out.error;
      ctrl_misaligned_load_o  <= lsu_fire & misaligned & ~is_write(lsu_cmd_i);
      ctrl_misaligned_store_o <= lsu_fire & misaligned & is_write(lsu_cmd_i);
      // a load ends with either its write-back or its bus error
      load_done_q             <= retire & ~is_write(act_out.cmd);
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      rf_data_o <= load_extract(rsp_out.data, act_out.cmd, act_out.addr[1:0]);
      rf_dest_o <= act_out.regdest;
    end
    // misaligned address wins if both happen in one cycle
    if (lsu_fire & misaligned) begin
      ctrl_exception_addr_o <= lsu_addr_i;
    end else if (retire & rsp_out.error) begin
      ctrl_exception_addr_o <= act_out.addr;
    end
  end

  ////////////////////
  // stall fsm
  ////////////////////

  assign lsu_ready_o = (state == ST_RUN) & req_in_ready;

  always_comb begin
    state_next = state;
    case (state)
      ST_RUN: begin
        if (load_accept) begin
          state_next = ST_READ;
        end else if (~req_in_ready) begin
          state_next = ST_FULL;
        end
      end
      ST_READ: begin
        if (load_done_q) begin
          state_next = ST_RUN;
        end
      end
      ST_FULL: begin
        if (req_in_ready) begin
          state_next = ST_RUN;
        end
      end
      default: state_next = ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (~rstn_i) begin
      state <= ST_RUN;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,

  data_bus_if.slave bus
);

  xlen_t mem [RAM_WORDS];

  logic [LFSR_WIDTH-1:0] lfsr;
  logic [RAM_AW-1:0]     word_idx;
  logic                  in_range;
  logic                  req_fire;

  ////////////////////
  // stall generator
  ////////////////////

  // galois lfsr, steps every cycle
  always_ff @(posedge clk_i) begin
    if (~rstn_i) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= {1'b0, lfsr[LFSR_WIDTH-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
    end
  end

  // low when the two bottom bits are both zero, about one cycle in four
  // also held off while the master cannot take a response
  assign bus.req_ready = (|lfsr[1:0]) & bus.rsp_ready;

  ////////////////////
  // array
  ////////////////////

  assign req_fire = bus.req_valid & bus.req_ready;
  assign word_idx = bus.req_addr[RAM_AW+1:2];
  // any set bit above the word index is outside the array
  assign in_range = ~|bus.req_addr[XLEN-1:RAM_AW+2];

  // per lane write, out of range writes are dropped
  always_ff @(posedge clk_i) begin
    if (req_fire && bus.req_write && in_range) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (bus.req_strobe[i]) begin
          mem[word_idx][8*i +: 8] <= bus.req_data[8*i +: 8];
        end
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  // exactly one cycle after the request is taken
  always_ff @(posedge clk_i) begin
    if (~rstn_i) begin
      bus.rsp_valid <= 1'b0;
    end else begin
      bus.rsp_valid <= req_fire;
    end
  end

  // writes also get a response, carrying the old word
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      bus.rsp_error <= ~in_range;
      bus.rsp_data  <= in_range ? mem[word_idx] : '0;
    end
  end

endmodule

//--- verilog/lsu_subsys.sv
`timescale 1ns/1ps

module lsu_subsys import lsu_pkg::*; (
  input  logic             clk_i,
  input  logic             rstn_i,

  // core side
  input  logic             lsu_valid_i,
  output logic             lsu_ready_o,
  input  lsu_cmd_e         lsu_cmd_i,
  input  xlen_t            lsu_addr_i,
  input  xlen_t            lsu_data_i,
  input  logic [RALEN-1:0] lsu_regdest_i,

  // register file write-back
  output xlen_t            rf_data_o,
  output logic             rf_wb_o,
  output logic [RALEN-1:0] rf_dest_o,

  // controller
  output logic             ctrl_misaligned_load_o,
  output logic             ctrl_misaligned_store_o,
  output logic             ctrl_bus_error_o,
  output xlen_t            ctrl_exception_addr_o
);

  // single master, single slave
  data_bus_if bus_if ();

  load_store_unit u_lsu (
    .clk_i                   (clk_i),
    .rstn_i                  (rstn_i),
    .lsu_valid_i             (lsu_valid_i),
    .lsu_ready_o             (lsu_ready_o),
    .lsu_cmd_i               (lsu_cmd_i),
    .lsu_addr_i              (lsu_addr_i),
    .lsu_data_i              (lsu_data_i),
    .lsu_regdest_i           (lsu_regdest_i),
    .rf_data_o               (rf_data_o),
    .rf_wb_o                 (rf_wb_o),
    .rf_dest_o               (rf_dest_o),
    .ctrl_misaligned_load_o  (ctrl_misaligned_load_o),
    .ctrl_misaligned_store_o (ctrl_misaligned_store_o),
    .ctrl_bus_error_o        (ctrl_bus_error_o),
    .ctrl_exception_addr_o   (ctrl_exception_addr_o),
    .bus                     (bus_if.master)
  );

  data_ram u_ram (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .bus    (bus_if.slave)
  );

endmodule

//--- sim/lsu_subsys_tb.sv
`timescale 1ns/1ps

module lsu_subsys_tb import lsu_pkg::*; ();

  // commands issued over the whole run, sizes the watchdog
  localparam int unsigned N_CMDS     = 385;
  // cycles a single access may take before it counts as lost
  localparam int unsigned WAIT_LIMIT = 100;

  logic             clk_i;
  logic             rstn_i;
  logic             lsu_valid_i;
  logic             lsu_ready_o;
  lsu_cmd_e         lsu_cmd_i;
  xlen_t            lsu_addr_i;
  xlen_t            lsu_data_i;
  logic [RALEN-1:0] lsu_regdest_i;
  xlen_t            rf_data_o;
  logic             rf_wb_o;
  logic [RALEN-1:0] rf_dest_o;
  logic             ctrl_misaligned_load_o;
  logic             ctrl_misaligned_store_o;
  logic             ctrl_bus_error_o;
  xlen_t            ctrl_exception_addr_o;

  // byte-wide reference of the ram contents
  logic [7:0] ref_mem [RAM_WORDS*NBYTES];

  integer      seed;
  int unsigned error_count;
  int unsigned test_errors_start;
  int unsigned pass_count;
  int unsigned fail_count;
  int unsigned stall_cycles;

  lsu_subsys UUT (
    .clk_i                   (clk_i),
    .rstn_i                  (rstn_i),
    .lsu_valid_i             (lsu_valid_i),
    .lsu_ready_o             (lsu_ready_o),
    .lsu_cmd_i               (lsu_cmd_i),
    .lsu_addr_i              (lsu_addr_i),
    .lsu_data_i              (lsu_data_i),
    .lsu_regdest_i           (lsu_regdest_i),
    .rf_data_o               (rf_data_o),
    .rf_wb_o                 (rf_wb_o),
    .rf_dest_o               (rf_dest_o),
    .ctrl_misaligned_load_o  (ctrl_misaligned_load_o),
    .ctrl_misaligned_store_o (ctrl_misaligned_store_o),
    .ctrl_bus_error_o        (ctrl_bus_error_o),
    .ctrl_exception_addr_o   (ctrl_exception_addr_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  ////////////////////
  // reference model
  ////////////////////

  function automatic int unsigned access_bytes(input lsu_cmd_e cmd);
    case (cmd)
      LSU_LOAD_BYTE, LSU_LOAD_BYTE_U, LSU_STORE_BYTE: return 1;
      LSU_LOAD_HALF, LSU_LOAD_HALF_U, LSU_STORE_HALF: return 2;
      default: return 4;
    endcase
  endfunction

  // little endian, byte i of the data goes to address + i
  task automatic model_store(input lsu_cmd_e cmd, input xlen_t addr, input xlen_t data);
    int unsigned base;
    base = addr % (RAM_WORDS * NBYTES);
    for (int i = 0; i < access_bytes(cmd); i++) begin
      ref_mem[base + i] = data[8*i +: 8];
    end
  endtask

  function automatic xlen_t model_load(input lsu_cmd_e cmd, input xlen_t addr);
    int unsigned base;
    int unsigned n;
    xlen_t       val;
    base = addr % (RAM_WORDS * NBYTES);
    n    = access_bytes(cmd);
    val  = '0;
    for (int i = 0; i < n; i++) begin
      val[8*i +: 8] = ref_mem[base + i];
    end
    // only the signed byte and half loads copy the top bit upward
    if (cmd == LSU_LOAD_BYTE && val[7]) begin
      val[XLEN-1:8] = '1;
    end
    if (cmd == LSU_LOAD_HALF && val[15]) begin
      val[XLEN-1:16] = '1;
    end
    return val;
  endfunction

  // preload value, every bit of the word index shows up in it
  function automatic xlen_t fill_word(input int unsigned idx);
    logic [7:0] w;
    w = idx[7:0];
    return {~w, w ^ 8'h5a, w + 8'h31, {w[3:0], w[7:4]}};
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic note_failure(input string what);
    $display("%s", what);
    error_count++;
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_reg(input string name, input logic [RALEN-1:0] got,
                           input logic [RALEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // strobe must be up and the address must match
  task automatic check_exc(input string name, input logic flag, input xlen_t addr,
                           input xlen_t exp_addr);
    if (flag !== 1'b1) begin
      $display("ERROR %s: got %h, expected %h", name, flag, 1'b1);
      error_count++;
    end else if (addr !== exp_addr) begin
      $display("ERROR ctrl_exception_addr_o: got %h, expected %h", addr, exp_addr);
      error_count++;
    end
  endtask

  task automatic start_test();
    test_errors_start = error_count;
  endtask

  task automatic report_test(input string name);
    if (error_count == test_errors_start) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: fail with %0d errors", name, error_count - test_errors_start);
    end
  endtask

  ////////////////////
  // drivers
  ////////////////////

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic drive_cmd(input lsu_cmd_e cmd, input xlen_t addr, input xlen_t data,
                           input logic [RALEN-1:0] rd);
    lsu_valid_i   = 1'b1;
    lsu_cmd_i     = cmd;
    lsu_addr_i    = addr;
    lsu_data_i    = data;
    lsu_regdest_i = rd;
    while (!lsu_ready_o) begin
      stall_cycles++;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    lsu_valid_i = 1'b0;
  endtask

  task automatic issue_store(input lsu_cmd_e cmd, input xlen_t addr, input xlen_t data);
    drive_cmd(cmd, addr, data, '0);
    model_store(cmd, addr, data);
  endtask

  // core stays stalled until the write-back cycle is over
  task automatic load_check(input lsu_cmd_e cmd, input xlen_t addr,
                            input logic [RALEN-1:0] rd);
    xlen_t       exp;
    int unsigned waited;
    logic        early_ready;
    exp         = model_load(cmd, addr);
    early_ready = 1'b0;
    waited      = 0;
    drive_cmd(cmd, addr, '0, rd);
    while (!rf_wb_o && waited < WAIT_LIMIT) begin
      if (lsu_ready_o) begin
        early_ready = 1'b1;
      end
      if (ctrl_bus_error_o) begin
        $display("unexpected bus error on the load from address %h", addr);
        error_count++;
      end
      waited++;
      @(negedge clk_i);
    end
    if (!rf_wb_o) begin
      $display("the load from address %h was never written back", addr);
      error_count++;
    end else begin
      check_word("rf_data_o", rf_data_o, exp);
      check_reg("rf_dest_o", rf_dest_o, rd);
      if (lsu_ready_o) begin
        early_ready = 1'b1;
      end
      @(negedge clk_i);
    end
    if (early_ready) begin
      $display("the core was released before the load from address %h finished", addr);
      error_count++;
    end
  endtask

  // bus error for the given address, then the core gets released without a write-back
  task automatic wait_bus_error(input xlen_t exp_addr);
    int unsigned waited;
    waited = 0;
    while (!ctrl_bus_error_o && waited < WAIT_LIMIT) begin
      if (rf_wb_o) begin
        note_failure("a write-back appeared for an access outside the ram");
      end
      waited++;
      @(negedge clk_i);
    end
    if (!ctrl_bus_error_o) begin
      $display("no bus error was reported for address %h", exp_addr);
      error_count++;
    end else begin
      check_exc("ctrl_bus_error_o", ctrl_bus_error_o, ctrl_exception_addr_o, exp_addr);
    end
    waited = 0;
    while (!lsu_ready_o && waited < WAIT_LIMIT) begin
      if (rf_wb_o) begin
        note_failure("a write-back appeared for an access outside the ram");
      end
      waited++;
      @(negedge clk_i);
    end
    if (!lsu_ready_o) begin
      note_failure("the core stayed stalled after a bus error");
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic preload_memory();
    for (int unsigned idx = 0; idx < RAM_WORDS; idx++) begin
      issue_store(LSU_STORE_WORD, idx * 4, fill_word(idx));
    end
  endtask

  task automatic test_store_load();
    start_test();
    issue_store(LSU_STORE_WORD, 32'h0000_01a0, $random(seed));
    load_check(LSU_LOAD_WORD, 32'h0000_01a0, 5'd5);
    report_test("store_load");
  endtask

  // each narrow store is followed by a word load of the whole word
  task automatic test_partial_stores();
    start_test();
    for (int off = 0; off < 4; off++) begin
      issue_store(LSU_STORE_BYTE, 32'h0000_00c0 + off, $random(seed));
      load_check(LSU_LOAD_WORD, 32'h0000_00c0, 5'd7);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_store(LSU_STORE_HALF, 32'h0000_00c4 + off, $random(seed));
      load_check(LSU_LOAD_WORD, 32'h0000_00c4, 5'd8);
    end
    report_test("partial_stores");
  endtask

  // first word has negative bytes and halves, second mostly positive ones
  task automatic test_extension();
    xlen_t base;
    start_test();
    for (int w = 0; w < 2; w++) begin
      base = 32'h0000_0200 + w * 4;
      issue_store(LSU_STORE_WORD, base, (w == 0) ? 32'h9370_fa85 : 32'h4c8e_05f1);
      for (int off = 0; off < 4; off++) begin
        load_check(LSU_LOAD_BYTE, base + off, RALEN'(10 + off));
        load_check(LSU_LOAD_BYTE_U, base + off, RALEN'(20 + off));
      end
      for (int off = 0; off < 4; off += 2) begin
        load_check(LSU_LOAD_HALF, base + off, RALEN'(14 + off));
        load_check(LSU_LOAD_HALF_U, base + off, RALEN'(24 + off));
      end
    end
    report_test("extension");
  endtask

  task automatic test_store_stream();
    xlen_t       addrs [$];
    xlen_t       addr;
    lsu_cmd_e    cmd;
    int unsigned sel;
    int unsigned stalls_before;
    start_test();
    stalls_before = stall_cycles;
    // stores go out back to back, valid stays up between them
    for (int n = 0; n < 40; n++) begin
      sel  = {$random(seed)} % 3;
      addr = ({$random(seed)} % RAM_WORDS) * 4;
      case (sel)
        0: begin
          cmd  = LSU_STORE_BYTE;
          addr = addr + {$random(seed)} % 4;
        end
        1: begin
          cmd  = LSU_STORE_HALF;
          addr = addr + 2 * ({$random(seed)} % 2);
        end
        default: cmd = LSU_STORE_WORD;
      endcase
      issue_store(cmd, addr, $random(seed));
      addrs.push_back({addr[XLEN-1:2], 2'b00});
    end
    if (stall_cycles == stalls_before) begin
      note_failure("the store stream never saw back-pressure from the ram");
    end
    foreach (addrs[i]) begin
      load_check(LSU_LOAD_WORD, addrs[i], RALEN'(i));
    end
    report_test("store_stream");
  endtask

  // flag is registered on the transfer edge, so it is up when drive_cmd returns
  task automatic test_misaligned();
    start_test();
    drive_cmd(LSU_LOAD_HALF, 32'h0000_0121, '0, 5'd3);
    check_exc("ctrl_misaligned_load_o", ctrl_misaligned_load_o, ctrl_exception_addr_o,
              32'h0000_0121);
    drive_cmd(LSU_STORE_WORD, 32'h0000_0132, 32'hffff_ffff, '0);
    check_exc("ctrl_misaligned_store_o", ctrl_misaligned_store_o, ctrl_exception_addr_o,
              32'h0000_0132);
    drive_cmd(LSU_STORE_HALF, 32'h0000_0143, 32'hffff_ffff, '0);
    check_exc("ctrl_misaligned_store_o", ctrl_misaligned_store_o, ctrl_exception_addr_o,
              32'h0000_0143);
    drive_cmd(LSU_LOAD_WORD, 32'h0000_0151, '0, 5'd4);
    check_exc("ctrl_misaligned_load_o", ctrl_misaligned_load_o, ctrl_exception_addr_o,
              32'h0000_0151);
    // dropped stores left these words alone
    load_check(LSU_LOAD_WORD, 32'h0000_0130, 5'd1);
    load_check(LSU_LOAD_WORD, 32'h0000_0140, 5'd2);
    report_test("misaligned");
  endtask

  task automatic test_bus_error();
    start_test();
    // low address bits alias word 4, which must stay untouched
    drive_cmd(LSU_STORE_WORD, RAM_WORDS * NBYTES + 32'h10, 32'h0bad_0bad, '0);
    wait_bus_error(RAM_WORDS * NBYTES + 32'h10);
    drive_cmd(LSU_LOAD_WORD, 32'h8000_0020, '0, 5'd9);
    wait_bus_error(32'h8000_0020);
    load_check(LSU_LOAD_WORD, 32'h0000_0010, 5'd6);
    report_test("bus_error");
  endtask

  ////////////////////
  // run control
  ////////////////////

  initial begin
    repeat (N_CMDS * 40 + 1000) @(posedge clk_i);
    $display("watchdog expired, the DUT stopped making progress");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk_i         = 1'b0;
    rstn_i        = 1'b0;
    lsu_valid_i   = 1'b0;
    lsu_cmd_i     = LSU_LOAD_WORD;
    lsu_addr_i    = '0;
    lsu_data_i    = '0;
    lsu_regdest_i = '0;
    seed          = 34500;
    error_count   = 0;
    pass_count    = 0;
    fail_count    = 0;
    stall_cycles  = 0;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    // idle state straight out of reset
    start_test();
    if (lsu_ready_o !== 1'b1) begin
      note_failure("lsu_ready_o is not high after reset");
    end
    if (rf_wb_o !== 1'b0 || ctrl_misaligned_load_o !== 1'b0 ||
        ctrl_misaligned_store_o !== 1'b0 || ctrl_bus_error_o !== 1'b0) begin
      note_failure("a strobe is active after reset");
    end
    report_test("reset");

    preload_memory();
    test_store_load();
    test_partial_stores();
    test_extension();
    test_store_stream();
    test_misaligned();
    test_bus_error();

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- lsu_subsys.f
verilog/lsu_pkg.sv
verilog/data_bus_if.sv
verilog/skid_buffer.sv
verilog/load_store_unit.sv
verilog/data_ram.sv
verilog/lsu_subsys.sv
sim/lsu_subsys_tb.sv

//--- Bender.yml
package:
  name: lsu_subsys

sources:
  # package first, then the interface and the modules bottom up
  - verilog/lsu_pkg.sv
  - verilog/data_bus_if.sv
  - verilog/skid_buffer.sv
  - verilog/load_store_unit.sv
  - verilog/data_ram.sv
  - verilog/lsu_subsys.sv
  - target: simulation
    files:
      - sim/lsu_subsys_tb.sv
